// ==== all.f ====
rtl/smem_pkg.sv
rtl/stream_demux.sv
rtl/stream_mux.sv
rtl/smem_arb.sv
rtl/smem_bank.sv
rtl/smem_subsys.sv
bench/smem_props.sv
bench/smem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module smem_tb -f all.f -o smem_sim

# An aborted simulation counts as a failure.
./obj_dir/smem_sim > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== bench/smem_tb.sv ====
`timescale 1ns/1ps

module smem_tb;
    import smem_pkg::*;

    localparam int NUM_TAGS = 1 << TAG_IN_WIDTH;

    logic clk = 1'b0;
    logic rst_n;
    logic [LANES-1:0]                    req_valid, req_rw, req_ready, rsp_tmask;
    logic [LANES-1:0][DATA_SIZE-1:0]     req_byteen;
    logic [LANES-1:0][ADDR_WIDTH-1:0]    req_addr;
    logic [LANES-1:0][DATA_WIDTH-1:0]    req_data, rsp_data;
    logic [LANES-1:0][TAG_IN_WIDTH-1:0]  req_tag;
    logic                                rsp_valid, rsp_ready;
    logic [TAG_IN_WIDTH-1:0]             rsp_tag;

    // Model state and expected responses, keyed by core tag.
    logic [DATA_WIDTH-1:0]               model_mem [NUM_BANKS][BANK_WORDS];
    logic                                exp_valid [NUM_TAGS];
    logic [LANES-1:0]                    exp_tmask [NUM_TAGS];
    logic [LANES-1:0][DATA_WIDTH-1:0]    exp_data  [NUM_TAGS];
    logic [LANES-1:0]                    g_valid, g_rw;
    logic [LANES-1:0][DATA_SIZE-1:0]     g_byteen;
    logic [LANES-1:0][ADDR_WIDTH-1:0]    g_addr;
    logic [LANES-1:0][DATA_WIDTH-1:0]    g_data;
    int errors = 0, checks = 0, outstanding = 0, test_base = 0, rdy_mode = 0;

    smem_subsys dut (.*);

    always #4 clk = ~clk;

    // 0 keeps ready high, 1 drops it about 40% of cycles, 2 holds it low.
    always @(negedge clk) begin
        rsp_ready = (rdy_mode == 0) || (rdy_mode == 1 && $urandom_range(99) >= 40);
    end

    function automatic void predict_read(input int bank, output logic [LANES-1:0] tmask,
                                         output logic [LANES-1:0][DATA_WIDTH-1:0] rdata);
        for (int l = 0; l < LANES; l++) begin
            tmask[l] = g_valid[l] && !g_rw[l];
            rdata[l] = model_mem[bank][g_addr[l]];      // Old data in a mixed group.
        end
        for (int l = 0; l < LANES; l++) begin
            for (int b = 0; b < DATA_SIZE; b++) begin
                if (g_valid[l] && g_rw[l] && g_byteen[l][b])
                    model_mem[bank][g_addr[l]][b*8 +: 8] = g_data[l][b*8 +: 8];
            end
        end
    endfunction

    // The one tag in flight when a single response is awaited.
    function automatic logic [TAG_IN_WIDTH-1:0] sole_pending_tag();
        logic [TAG_IN_WIDTH-1:0] t;
        t = '0;
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (exp_valid[i]) t = TAG_IN_WIDTH'(i);
        end
        return t;
    endfunction

    task automatic fail_value(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_tmask(input logic [LANES-1:0] got, input logic [LANES-1:0] exp);
        checks++;
        if (got !== exp) fail_value($sformatf("tmask got %b expected %b", got, exp));
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input int lane);
        checks++;
        if (got !== exp) fail_value($sformatf("lane %0d data got %h expected %h", lane, got, exp));
    endtask

    task automatic check_tag(input logic [TAG_IN_WIDTH-1:0] got,
                             input logic [TAG_IN_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) fail_value($sformatf("tag got %0d expected %0d", got, exp));
    endtask

    // Compare process, sampled at the transfer edge.
    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (outstanding == 1) check_tag(rsp_tag, sole_pending_tag());
            if (!exp_valid[rsp_tag]) begin
                fail_value($sformatf("unexpected response with tag %0d", rsp_tag));
            end else begin
                check_tmask(rsp_tmask, exp_tmask[rsp_tag]);
                for (int l = 0; l < LANES; l++)
                    if (exp_tmask[rsp_tag][l]) check_data(rsp_data[l], exp_data[rsp_tag][l], l);
                exp_valid[rsp_tag] = 1'b0;
                outstanding--;
            end
        end
    end

    task automatic set_lane(input int l, input logic rw, input logic [DATA_SIZE-1:0] be,
                            input int addr, input logic [DATA_WIDTH-1:0] data);
        g_valid[l]  = 1'b1;
        g_rw[l]     = rw;
        g_byteen[l] = be;
        g_addr[l]   = ADDR_WIDTH'(addr);
        g_data[l]   = data;
    endtask

    // Raises valid only once every lane of the group can transfer together.
    task automatic issue_group(input logic [TAG_IN_WIDTH-1:0] tag);
        logic [LANES-1:0]                 tmask;
        logic [LANES-1:0][DATA_WIDTH-1:0] rdata;
        int waited;
        predict_read(int'(tag[TAG_SEL_IDX +: LOG_NUM_BANKS]), tmask, rdata);
        if (|tmask) begin
            exp_valid[tag] = 1'b1;
            exp_tmask[tag] = tmask;
            exp_data[tag]  = rdata;
            outstanding++;
        end
        @(negedge clk);
        {req_rw, req_byteen, req_addr, req_data} = {g_rw, g_byteen, g_addr, g_data};
        req_tag = {LANES{tag}};
        waited  = 0;
        #1;
        while ((req_ready & g_valid) != g_valid && waited < 200) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (waited >= 200) begin
            $display("Timeout: request group with tag %0d was never accepted", tag);
            errors++;
        end else begin
            req_valid = g_valid;
            @(posedge clk);
            @(negedge clk);
            req_valid = '0;
        end
        g_valid = '0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (outstanding != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (outstanding != 0) begin
            $display("Timeout: %0d responses still missing after %0d cycles", outstanding, n);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-24s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        logic [TAG_IN_WIDTH-1:0] tag;
        int tries;
        void'($urandom(37140));
        {req_valid, req_rw, req_byteen, req_addr, req_data, req_tag} = '0;
        {g_valid, g_rw, g_byteen, g_addr, g_data} = '0;
        rsp_ready = 1'b1;
        foreach (exp_valid[t]) exp_valid[t] = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (rsp_valid !== 1'b0 || req_ready !== '1) begin
            $display("Idle state wrong after reset: rsp_valid or req_ready not as expected");
            errors++;
        end
        end_test("reset");

        // ------------------------------------------------------------------
        // Fill every bank with a pattern of the whole address
        // ------------------------------------------------------------------
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int a = 0; a < BANK_WORDS; a += 2) begin
                set_lane(0, 1'b1, '1, a, {8'hc3, 8'(b), 8'(a), ~8'(a)});
                set_lane(1, 1'b1, '1, a + 1, {8'hc3, 8'(b), 8'(a + 1), ~8'(a + 1)});
                issue_group(TAG_IN_WIDTH'(b));
            end
        end
        end_test("fill");

        for (int b = 0; b < NUM_BANKS; b++) begin
            set_lane(0, 1'b1, '1, 5 + b, 32'h1234_5600 + b);
            issue_group({4'd1, 2'(b)});
            set_lane(0, 1'b0, '0, 5 + b, '0);
            issue_group({4'd2, 2'(b)});
            wait_idle(50);
        end
        end_test("write then read");

        set_lane(0, 1'b1, 4'b0101, 9, 32'haabb_ccdd);
        issue_group(6'd3);
        set_lane(0, 1'b1, 4'b0011, 9, 32'h1111_2222);
        set_lane(1, 1'b1, 4'b0110, 9, 32'h3333_4444);
        issue_group(6'd7);
        set_lane(0, 1'b0, '0, 9, '0);
        issue_group(6'd11);
        wait_idle(50);
        end_test("byte enables");

        set_lane(0, 1'b0, '0, 3, '0);
        set_lane(1, 1'b0, '0, 40, '0);
        issue_group(6'd14);
        set_lane(0, 1'b1, '1, 20, 32'hdead_beef);
        set_lane(1, 1'b0, '0, 20, '0);
        issue_group(6'd18);
        wait_idle(50);
        end_test("two lane groups");

        rdy_mode = 1;
        for (int g = 0; g < 300; g++) begin
            tries = 0;
            tag = TAG_IN_WIDTH'($urandom_range(NUM_TAGS - 1));
            while (exp_valid[tag] && tries < 200) begin
                @(negedge clk);
                tag = TAG_IN_WIDTH'($urandom_range(NUM_TAGS - 1));
                tries++;
            end
            if (tries >= 200) begin
                $display("Timeout: no free tag found for random group %0d", g);
                errors++;
            end
            for (int l = 0; l < LANES; l++)
                set_lane(l, 1'($urandom), 4'($urandom), $urandom_range(15), $urandom);
            issue_group(tag);
        end
        rdy_mode = 0;
        wait_idle(500);
        end_test("random traffic");

        rdy_mode = 2;
        for (int b = 0; b < NUM_BANKS; b++) begin
            set_lane(0, 1'b0, '0, b, '0);
            set_lane(1, 1'b0, '0, b + 8, '0);
            issue_group({4'(8 + b), 2'(b)});
        end
        repeat (20) @(negedge clk);
        rdy_mode = 0;
        wait_idle(12);
        end_test("stalled banks");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/smem_props.sv ====
`timescale 1ns/1ps

module smem_props #(
    parameter int n_in   = 2,
    parameter int data_w = 1
) (
    input logic              clk,
    input logic              rst_n,
    input logic [n_in-1:0]   ready_in,
    input logic              valid_out,
    input logic [data_w-1:0] data_out,
    input logic              ready_out
);

    // A stalled output keeps its valid until the transfer.
    valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> valid_out)
        else $error("stream_mux dropped valid_out while stalled");

    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> $stable(data_out))
        else $error("stream_mux changed data_out while stalled");

    one_grant: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ready_in))
        else $error("stream_mux granted more than one input");

endmodule

bind stream_mux smem_props #(.n_in(n_in), .data_w($bits(payload_t))) props (
    .clk(clk), .rst_n(rst_n), .ready_in(ready_in), .valid_out(valid_out),
    .data_out(data_out), .ready_out(ready_out)
);

// ==== rtl/smem_subsys.sv ====
`timescale 1ns/1ps

module smem_subsys (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [smem_pkg::LANES-1:0]                             req_valid,
    input  logic [smem_pkg::LANES-1:0]                             req_rw,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_SIZE-1:0]    req_byteen,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]   req_addr,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]   req_data,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::TAG_IN_WIDTH-1:0] req_tag,
    output logic [smem_pkg::LANES-1:0]                             req_ready,
    output logic                                                   rsp_valid,
    output logic [smem_pkg::LANES-1:0]                             rsp_tmask,
    output logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]   rsp_data,
    output logic [smem_pkg::TAG_IN_WIDTH-1:0]                      rsp_tag,
    input  logic                                                   rsp_ready
);
    import smem_pkg::*;

    // ----------------------------------------------------------------------
    // Arbiter to bank wiring
    // ----------------------------------------------------------------------
    logic [NUM_BANKS-1:0][LANES-1:0]                    bank_req_valid;
    logic [NUM_BANKS-1:0][LANES-1:0]                    bank_req_rw;
    logic [NUM_BANKS-1:0][LANES-1:0][DATA_SIZE-1:0]     bank_req_byteen;
    logic [NUM_BANKS-1:0][LANES-1:0][ADDR_WIDTH-1:0]    bank_req_addr;
    logic [NUM_BANKS-1:0][LANES-1:0][DATA_WIDTH-1:0]    bank_req_data;
    logic [NUM_BANKS-1:0][LANES-1:0][TAG_OUT_WIDTH-1:0] bank_req_tag;
    logic [NUM_BANKS-1:0][LANES-1:0]                    bank_req_ready;
    logic [NUM_BANKS-1:0]                               bank_rsp_valid;
    logic [NUM_BANKS-1:0][LANES-1:0]                    bank_rsp_tmask;
    logic [NUM_BANKS-1:0][LANES-1:0][DATA_WIDTH-1:0]    bank_rsp_data;
    logic [NUM_BANKS-1:0][TAG_OUT_WIDTH-1:0]            bank_rsp_tag;
    logic [NUM_BANKS-1:0]                               bank_rsp_ready;

    smem_arb arb (.*);                                  // Port names match one to one.

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        smem_bank bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_valid  (bank_req_valid[b]),
            .req_rw     (bank_req_rw[b]),
            .req_byteen (bank_req_byteen[b]),
            .req_addr   (bank_req_addr[b]),
            .req_data   (bank_req_data[b]),
            .req_tag    (bank_req_tag[b]),
            .req_ready  (bank_req_ready[b]),
            .rsp_valid  (bank_rsp_valid[b]),
            .rsp_tmask  (bank_rsp_tmask[b]),
            .rsp_data   (bank_rsp_data[b]),
            .rsp_tag    (bank_rsp_tag[b]),
            .rsp_ready  (bank_rsp_ready[b])
        );
    end

endmodule

// ==== rtl/smem_bank.sv ====
`timescale 1ns/1ps

module smem_bank (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [smem_pkg::LANES-1:0]                             req_valid,
    input  logic [smem_pkg::LANES-1:0]                             req_rw,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_SIZE-1:0]    req_byteen,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]   req_addr,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]   req_data,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::TAG_OUT_WIDTH-1:0] req_tag,
    output logic [smem_pkg::LANES-1:0]                             req_ready,
    output logic                                                   rsp_valid,
    output logic [smem_pkg::LANES-1:0]                             rsp_tmask,
    output logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]   rsp_data,
    output logic [smem_pkg::TAG_OUT_WIDTH-1:0]                     rsp_tag,
    input  logic                                                   rsp_ready
);
    import smem_pkg::*;

    logic [DATA_WIDTH-1:0]    mem [BANK_WORDS];
    logic [TAG_OUT_WIDTH-1:0] lead_tag;
    logic [LANES-1:0]         group;
    logic [LANES-1:0]         rd_mask;
    logic                     accept_en;

    // ----------------------------------------------------------------------
    // Tag group of the lowest valid lane
    // ----------------------------------------------------------------------
    always_comb begin
        lead_tag = '0;
        for (int l = LANES - 1; l >= 0; l--) begin
            if (req_valid[l]) begin
                lead_tag = req_tag[l];
            end
        end
        for (int l = 0; l < LANES; l++) begin
            group[l] = req_valid[l] && (req_tag[l] == lead_tag);
        end
    end

    assign accept_en = !rsp_valid || rsp_ready;         // Response register free.
    assign req_ready = accept_en ? group : '0;
    assign rd_mask   = group & ~req_rw;

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept_en) begin
            // Later lanes overwrite earlier ones on the same word.
            for (int l = 0; l < LANES; l++) begin
                for (int b = 0; b < DATA_SIZE; b++) begin
                    if (group[l] && req_rw[l] && req_byteen[l][b]) begin
                        mem[req_addr[l]][b*8 +: 8] <= req_data[l][b*8 +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read response
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept_en) begin
            rsp_valid <= |rd_mask;                      // Write-only groups answer nothing.
        end
    end

    always_ff @(posedge clk) begin
        if (accept_en && |rd_mask) begin
            rsp_tmask <= rd_mask;
            rsp_tag   <= lead_tag;
            for (int l = 0; l < LANES; l++) begin
                rsp_data[l] <= mem[req_addr[l]];        // Old data on a mixed group.
            end
        end
    end

endmodule

// ==== rtl/smem_arb.sv ====
`timescale 1ns/1ps

module smem_arb (
    input  logic clk,
    input  logic rst_n,

    // Core request
    input  logic [smem_pkg::LANES-1:0]                                 req_valid,
    input  logic [smem_pkg::LANES-1:0]                                 req_rw,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_SIZE-1:0]        req_byteen,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::ADDR_WIDTH-1:0]       req_addr,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]       req_data,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::TAG_IN_WIDTH-1:0]     req_tag,
    output logic [smem_pkg::LANES-1:0]                                 req_ready,

    // Bank requests
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]        bank_req_valid,
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]        bank_req_rw,
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]
                 [smem_pkg::DATA_SIZE-1:0]                             bank_req_byteen,
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]
                 [smem_pkg::ADDR_WIDTH-1:0]                            bank_req_addr,
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]
                 [smem_pkg::DATA_WIDTH-1:0]                            bank_req_data,
    output logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]
                 [smem_pkg::TAG_OUT_WIDTH-1:0]                         bank_req_tag,
    input  logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]        bank_req_ready,

    // Bank responses
    input  logic [smem_pkg::NUM_BANKS-1:0]                             bank_rsp_valid,
    input  logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]        bank_rsp_tmask,
    input  logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::LANES-1:0]
                 [smem_pkg::DATA_WIDTH-1:0]                            bank_rsp_data,
    input  logic [smem_pkg::NUM_BANKS-1:0][smem_pkg::TAG_OUT_WIDTH-1:0] bank_rsp_tag,
    output logic [smem_pkg::NUM_BANKS-1:0]                             bank_rsp_ready,

    // Core response
    output logic                                                       rsp_valid,
    output logic [smem_pkg::LANES-1:0]                                 rsp_tmask,
    output logic [smem_pkg::LANES-1:0][smem_pkg::DATA_WIDTH-1:0]       rsp_data,
    output logic [smem_pkg::TAG_IN_WIDTH-1:0]                          rsp_tag,
    input  logic                                                       rsp_ready
);
    import smem_pkg::*;

    localparam logic [TAG_IN_WIDTH-1:0] LOW_MASK = TAG_IN_WIDTH'((1 << TAG_SEL_IDX) - 1);

    logic [LANES-1:0][LOG_NUM_BANKS-1:0]     req_sel;
    req_payload_t [LANES-1:0]                req_pld;
    req_payload_t [NUM_BANKS-1:0][LANES-1:0] bank_pld;
    rsp_payload_t [NUM_BANKS-1:0]            rsp_pld;
    rsp_payload_t                            rsp_out;

    // ----------------------------------------------------------------------
    // Request path
    // ----------------------------------------------------------------------
    for (genvar l = 0; l < LANES; l++) begin : g_req_lane
        logic [TAG_IN_WIDTH-1:0] tag_hi;
        logic [TAG_IN_WIDTH-1:0] tag_lo;

        assign req_sel[l] = req_tag[l][TAG_SEL_IDX +: LOG_NUM_BANKS];
        // Upper bits shift down over the removed field.
        assign tag_hi = (req_tag[l] >> (TAG_SEL_IDX + LOG_NUM_BANKS)) << TAG_SEL_IDX;
        assign tag_lo = req_tag[l] & LOW_MASK;

        assign req_pld[l].tag    = TAG_OUT_WIDTH'(tag_hi | tag_lo);
        assign req_pld[l].addr   = req_addr[l];
        assign req_pld[l].rw     = req_rw[l];
        assign req_pld[l].byteen = req_byteen[l];
        assign req_pld[l].data   = req_data[l];
    end

    stream_demux #(
        .payload_t (req_payload_t),
        .n_out     (NUM_BANKS)
    ) req_demux (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_in    (req_sel),
        .valid_in  (req_valid),
        .data_in   (req_pld),
        .ready_in  (req_ready),
        .valid_out (bank_req_valid),
        .data_out  (bank_pld),
        .ready_out (bank_req_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        for (genvar l = 0; l < LANES; l++) begin : g_lane
            assign bank_req_tag[b][l]    = bank_pld[b][l].tag;
            assign bank_req_addr[b][l]   = bank_pld[b][l].addr;
            assign bank_req_rw[b][l]     = bank_pld[b][l].rw;
            assign bank_req_byteen[b][l] = bank_pld[b][l].byteen;
            assign bank_req_data[b][l]   = bank_pld[b][l].data;
        end

        // Bank index goes back in at TAG_SEL_IDX.
        logic [TAG_IN_WIDTH-1:0] tag_w;
        assign tag_w = TAG_IN_WIDTH'(bank_rsp_tag[b]);
        assign rsp_pld[b].tag   = ((tag_w >> TAG_SEL_IDX) << (TAG_SEL_IDX + LOG_NUM_BANKS))
                                | (TAG_IN_WIDTH'(b) << TAG_SEL_IDX)
                                | (tag_w & LOW_MASK);
        assign rsp_pld[b].tmask = bank_rsp_tmask[b];
        assign rsp_pld[b].data  = bank_rsp_data[b];
    end

    // ----------------------------------------------------------------------
    // Response path
    // ----------------------------------------------------------------------
    stream_mux #(
        .payload_t (rsp_payload_t),
        .n_in      (NUM_BANKS)
    ) rsp_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (bank_rsp_valid),
        .data_in   (rsp_pld),
        .ready_in  (bank_rsp_ready),
        .valid_out (rsp_valid),
        .data_out  (rsp_out),
        .ready_out (rsp_ready)
    );

    assign rsp_tag   = rsp_out.tag;
    assign rsp_tmask = rsp_out.tmask;
    assign rsp_data  = rsp_out.data;

endmodule

// ==== rtl/stream_mux.sv ====
`timescale 1ns/1ps

module stream_mux #(
    parameter type payload_t = logic,
    parameter int  n_in      = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [n_in-1:0]     valid_in,
    input  payload_t [n_in-1:0] data_in,
    output logic [n_in-1:0]     ready_in,
    output logic                valid_out,
    output payload_t            data_out,
    input  logic                ready_out
);
    localparam int SEL_W = (n_in > 1) ? $clog2(n_in) : 1;

    logic [SEL_W-1:0] rr_ptr;                   // First input to search.
    logic [SEL_W-1:0] win_idx;
    logic             win_found;
    logic             load_en;

    assign load_en = !valid_out || ready_out;   // Register free or draining.

    // ----------------------------------------------------------------------
    // Round-robin search starting at rr_ptr
    // ----------------------------------------------------------------------
    always_comb begin
        int idx;
        win_found = 1'b0;
        win_idx   = '0;
        for (int k = 0; k < n_in; k++) begin
            idx = (int'(rr_ptr) + k) % n_in;
            if (!win_found && valid_in[idx]) begin
                win_found = 1'b1;
                win_idx   = SEL_W'(idx);
            end
        end
    end

    always_comb begin
        ready_in = '0;
        if (win_found && load_en) begin
            ready_in[win_idx] = 1'b1;           // Winner only.
        end
    end

    // ----------------------------------------------------------------------
    // Output register and pointer update
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            rr_ptr    <= '0;
        end else if (load_en) begin
            valid_out <= win_found;
            if (win_found) begin
                // Next search starts just past the winner.
                rr_ptr <= (int'(win_idx) == n_in - 1) ? '0 : win_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && win_found) begin
            data_out <= data_in[win_idx];
        end
    end

endmodule

// ==== rtl/stream_demux.sv ====
`timescale 1ns/1ps

module stream_demux #(
    parameter type payload_t = logic,
    parameter int  n_out     = 2
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [smem_pkg::LANES-1:0][smem_pkg::LOG_NUM_BANKS-1:0] sel_in,
    input  logic [smem_pkg::LANES-1:0]                              valid_in,
    input  payload_t [smem_pkg::LANES-1:0]                          data_in,
    output logic [smem_pkg::LANES-1:0]                              ready_in,
    output logic [n_out-1:0][smem_pkg::LANES-1:0]                   valid_out,
    output payload_t [n_out-1:0][smem_pkg::LANES-1:0]               data_out,
    input  logic [n_out-1:0][smem_pkg::LANES-1:0]                   ready_out
);
    import smem_pkg::*;

    logic [LANES-1:0] fire;

    // A lane only looks at the register it targets.
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            ready_in[l] = !valid_out[sel_in[l]][l] || ready_out[sel_in[l]][l];
            fire[l]     = valid_in[l] && ready_in[l];
        end
    end

    // ----------------------------------------------------------------------
    // Output registers, one per target and lane
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= '0;
        end else begin
            for (int o = 0; o < n_out; o++) begin
                for (int l = 0; l < LANES; l++) begin
                    if (fire[l] && int'(sel_in[l]) == o) begin
                        valid_out[o][l] <= 1'b1;            // Load, possibly while draining.
                    end else if (ready_out[o][l]) begin
                        valid_out[o][l] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < n_out; o++) begin
            for (int l = 0; l < LANES; l++) begin
                if (fire[l] && int'(sel_in[l]) == o) begin
                    data_out[o][l] <= data_in[l];
                end
            end
        end
    end

endmodule

// ==== rtl/smem_pkg.sv ====
package smem_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int NUM_BANKS     = 4;
    localparam int LOG_NUM_BANKS = $clog2(NUM_BANKS);
    localparam int LANES         = 2;
    localparam int DATA_SIZE     = 4;                   // Bytes per word.
    localparam int DATA_WIDTH    = 8 * DATA_SIZE;
    localparam int ADDR_WIDTH    = 6;                   // Word address within a bank.
    localparam int BANK_WORDS    = 1 << ADDR_WIDTH;

    // ----------------------------------------------------------------------
    // Tags
    // ----------------------------------------------------------------------
    localparam int TAG_IN_WIDTH  = 6;                   // Core side.
    localparam int TAG_SEL_IDX   = 0;                   // Bank select field position.
    localparam int TAG_OUT_WIDTH = TAG_IN_WIDTH - LOG_NUM_BANKS;

    // One lane of a bank-side request.
    typedef struct packed {
        logic [TAG_OUT_WIDTH-1:0] tag;
        logic [ADDR_WIDTH-1:0]    addr;
        logic                     rw;                   // 1 for write.
        logic [DATA_SIZE-1:0]     byteen;
        logic [DATA_WIDTH-1:0]    data;
    } req_payload_t;

    // One merged response toward the core.
    typedef struct packed {
        logic [TAG_IN_WIDTH-1:0]          tag;
        logic [LANES-1:0]                 tmask;
        logic [LANES-1:0][DATA_WIDTH-1:0] data;
    } rsp_payload_t;

endpackage
